/* src/conv_out_pkg.sv */
`default_nettype none

package conv_out_pkg;

  //////////////////////////////////////////////////
  // array geometry and widths
  //////////////////////////////////////////////////
  localparam int sa_row_num = 4;
  localparam int sa_column_num = 3;
  localparam int fifo_count = sa_row_num * sa_column_num;
  localparam int fifo_idx_width = 4;
  localparam int column_num = 4;
  localparam int pixel_width = 8;

  // two pixels by one weight per processing element
  localparam int out_word_width = pixel_width * 2 * 1 * column_num;
  localparam int fifo_word_width = 2 * out_word_width;
  localparam int wb_sel_width = out_word_width / 8;

  //////////////////////////////////////////////////
  // shared structs
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [out_word_width-1:0] hi;
    logic [out_word_width-1:0] lo;
  } fifo_word_t;

  typedef struct packed {
    logic [15:0] ox_start;
    logic [15:0] oy_start;
    logic [15:0] of_start;
    logic [15:0] pox;
    logic [15:0] poy;
    logic [15:0] pof;
    logic [3:0]  ox_in_2pow;
    logic [3:0]  of_in_2pow;
  } tile_cfg_t;

  typedef struct packed {
    logic                      valid;
    logic [fifo_idx_width-1:0] index;
    fifo_word_t                data;
  } result_push_t;

  typedef struct packed {
    logic [15:0]               y_idx;
    logic [15:0]               x_idx;
    logic [15:0]               f_idx;
    logic [out_word_width-1:0] data;
  } out_item_t;

  // 16 channels per fifo row in 8x8 mode, 32 in 1x8 mode
  function automatic logic [15:0] channels_per_group(input logic mode);
    return mode ? 16'd32 : 16'd16;
  endfunction

  function automatic logic [3:0] channels_log2(input logic mode);
    return mode ? 4'd5 : 4'd4;
  endfunction

endpackage

`default_nettype wire

/* src/row_result_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module row_result_fifo
  import conv_out_pkg::*;
#(
  parameter int fifo_depth = 64
)
(
  input  logic       clk,
  input  logic       reset,
  input  logic       push,
  input  fifo_word_t push_data,
  input  logic       pop,
  output fifo_word_t pop_data,
  output logic       empty
);

  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

  fifo_word_t mem [fifo_depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0] count;
  logic full;
  logic do_push;
  logic do_pop;

  assign empty = (count == '0);
  assign full = (count == (ptr_width+1)'(fifo_depth));

  // full pushes and empty pops are dropped
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop)
      begin
        count <= count + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // storage and registered read port
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop)
    begin
      pop_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

/* src/conv_fifo_out_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_fifo_out_controller
  import conv_out_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic                      mode,
  input  tile_cfg_t                 cfg,
  input  logic                      ready,
  output logic [fifo_count-1:0]     fifo_rds,
  output logic [fifo_idx_width-1:0] fifo_sel,
  input  fifo_word_t                fifo_data,
  output out_item_t                 item,
  output logic                      item_valid,
  output logic                      last,
  output logic                      busy
);

  logic running;
  logic launch;
  logic [15:0] oy_cnt;
  logic [15:0] of_cnt;
  logic [15:0] ch_cnt;
  logic [15:0] group_size;
  logic [3:0] group_log2;
  logic [15:0] chan_pos;
  logic [15:0] fifo_num;
  logic step;
  logic pop_now;
  logic ch_end;
  logic of_end;
  logic oy_end;

  // tags delayed one cycle to line up with fifo read data
  logic [15:0] y_r;
  logic [15:0] x_r;
  logic [15:0] f_r;
  logic half_hi_r;
  logic popped_r;
  fifo_word_t held_entry;
  fifo_word_t cur_entry;

  assign group_size = channels_per_group(mode);
  assign group_log2 = channels_log2(mode);

  // 1-based channel offset inside the tile
  assign chan_pos = of_cnt - 16'd1 + ch_cnt;

  assign launch = start && !busy;

  // one item in flight at most
  assign step = running && ready && !item_valid;

  // mode 1 pops on odd channels and reads the upper half on even ones
  assign pop_now = !mode || ch_cnt[0];

  //////////////////////////////////////////////////
  // loop ends
  //////////////////////////////////////////////////
  assign ch_end = (chan_pos == cfg.pof) || (ch_cnt == group_size);
  assign of_end = ch_end && (chan_pos == cfg.pof);
  assign oy_end = of_end && (oy_cnt == cfg.poy);

  assign fifo_num = (oy_cnt - 16'd1) * 16'(sa_row_num)
                  + ((of_cnt - 16'd1) >> group_log2);

  assign fifo_rds = (step && pop_now)
                  ? ({{(fifo_count-1){1'b0}}, 1'b1} << fifo_num[fifo_idx_width-1:0])
                  : '0;

  // busy outlasts the run flag until the writer drains
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      running <= 1'b0;
      busy <= 1'b0;
    end
    else if (launch)
    begin
      running <= 1'b1;
      busy <= 1'b1;
    end
    else
    begin
      if (step && oy_end)
      begin
        running <= 1'b0;
      end
      if (!running && ready && !item_valid)
      begin
        busy <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // oy / of / channel counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset || launch)
    begin
      oy_cnt <= 16'd1;
      of_cnt <= 16'd1;
      ch_cnt <= 16'd1;
    end
    else if (step)
    begin
      if (ch_end)
      begin
        ch_cnt <= 16'd1;
      end
      else
      begin
        ch_cnt <= ch_cnt + 16'd1;
      end

      if (of_end)
      begin
        of_cnt <= 16'd1;
      end
      else if (ch_end)
      begin
        of_cnt <= of_cnt + group_size;
      end

      if (oy_end)
      begin
        oy_cnt <= 16'd1;
      end
      else if (of_end)
      begin
        oy_cnt <= oy_cnt + 16'd1;
      end
    end
  end

  // item handshake and fifo select
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      item_valid <= 1'b0;
      last <= 1'b0;
      fifo_sel <= '0;
    end
    else
    begin
      item_valid <= step;
      if (step)
      begin
        last <= oy_end;
        fifo_sel <= fifo_num[fifo_idx_width-1:0];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (step)
    begin
      y_r <= cfg.oy_start - 16'd1 + oy_cnt;
      x_r <= cfg.ox_start;
      f_r <= cfg.of_start - 16'd1 + chan_pos;
      half_hi_r <= mode && !ch_cnt[0];
      popped_r <= pop_now;
    end
    // keep the popped entry for its second half
    if (item_valid && popped_r)
    begin
      held_entry <= fifo_data;
    end
  end

  assign cur_entry = popped_r ? fifo_data : held_entry;

  always_comb
  begin
    item.y_idx = y_r;
    item.x_idx = x_r;
    item.f_idx = f_r;
    item.data = half_hi_r ? cur_entry.hi : cur_entry.lo;
  end

endmodule

`default_nettype wire

/* src/out_buf_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module out_buf_writer
  import conv_out_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  out_item_t                 item,
  input  logic                      item_valid,
  input  logic                      last,
  input  logic [31:0]               out_base,
  input  logic [3:0]                of_in_2pow,
  output logic                      ready,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output logic [31:0]               wb_adr,
  output logic [out_word_width-1:0] wb_dat_w,
  output logic [wb_sel_width-1:0]   wb_sel,
  input  logic                      wb_ack,
  output logic                      tile_done
);

  logic [31:0] row_offset;
  logic [31:0] item_adr;
  logic held_last;
  logic capture;
  logic finish;

  //////////////////////////////////////////////////
  // buffer address
  //////////////////////////////////////////////////
  // one row of output channels spans 2^of_in_2pow words
  assign row_offset = 32'(item.y_idx) << of_in_2pow;
  assign item_adr = out_base + row_offset + 32'(item.f_idx);

  assign capture = item_valid && !wb_cyc;
  assign finish = wb_cyc && wb_ack;

  // empty whenever no bus cycle is open
  assign ready = !wb_cyc;

  //////////////////////////////////////////////////
  // wishbone classic write cycle
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wb_cyc <= 1'b0;
      held_last <= 1'b0;
      tile_done <= 1'b0;
    end
    else
    begin
      tile_done <= 1'b0;
      if (finish)
      begin
        wb_cyc <= 1'b0;
        tile_done <= held_last;
        held_last <= 1'b0;
      end
      else if (capture)
      begin
        wb_cyc <= 1'b1;
        held_last <= last;
      end
    end
  end

  // address and data held until ack
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      wb_adr <= item_adr;
      wb_dat_w <= item.data;
    end
  end

  // write only, full word lanes
  assign wb_stb = wb_cyc;
  assign wb_we = wb_cyc;
  assign wb_sel = {wb_sel_width{wb_cyc}};

endmodule

`default_nettype wire

/* src/conv_out_top.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_out_top
  import conv_out_pkg::*;
#(
  parameter int fifo_depth = 64
)
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic                      mode,
  input  tile_cfg_t                 cfg,
  input  logic [31:0]               out_base,
  input  result_push_t              push,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output logic [31:0]               wb_adr,
  output logic [out_word_width-1:0] wb_dat_w,
  output logic [wb_sel_width-1:0]   wb_sel,
  input  logic                      wb_ack,
  output logic                      tile_done,
  output logic                      busy
);

  logic [fifo_count-1:0] fifo_rds;
  logic [fifo_count-1:0] fifo_push;
  logic [fifo_idx_width-1:0] fifo_sel;
  fifo_word_t fifo_pop_data [fifo_count];
  fifo_word_t fifo_data;
  out_item_t item;
  logic item_valid;
  logic last;
  logic ready;

  //////////////////////////////////////////////////
  // result fifo grid
  //////////////////////////////////////////////////
  for (genvar k = 0; k < fifo_count; k++)
  begin : gen_fifo
    assign fifo_push[k] = push.valid && (push.index == fifo_idx_width'(k));

    row_result_fifo #(
      .fifo_depth(fifo_depth)
    ) u_fifo (
      .clk      (clk),
      .reset    (reset),
      .push     (fifo_push[k]),
      .push_data(push.data),
      .pop      (fifo_rds[k]),
      .pop_data (fifo_pop_data[k]),
      .empty    ()
    );
  end

  // read data from the fifo popped last cycle
  assign fifo_data = fifo_pop_data[fifo_sel];

  conv_fifo_out_controller u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .mode      (mode),
    .cfg       (cfg),
    .ready     (ready),
    .fifo_rds  (fifo_rds),
    .fifo_sel  (fifo_sel),
    .fifo_data (fifo_data),
    .item      (item),
    .item_valid(item_valid),
    .last      (last),
    .busy      (busy)
  );

  out_buf_writer u_writer (
    .clk       (clk),
    .reset     (reset),
    .item      (item),
    .item_valid(item_valid),
    .last      (last),
    .out_base  (out_base),
    .of_in_2pow(cfg.of_in_2pow),
    .ready     (ready),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_sel    (wb_sel),
    .wb_ack    (wb_ack),
    .tile_done (tile_done)
  );

endmodule

`default_nettype wire

/* verification/conv_out_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_out_tb
  import conv_out_pkg::*;
;

  logic clk;
  logic reset;
  logic start;
  logic mode;
  tile_cfg_t cfg;
  logic [31:0] out_base;
  result_push_t push;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [31:0] wb_adr;
  logic [out_word_width-1:0] wb_dat_w;
  logic [wb_sel_width-1:0] wb_sel;
  logic wb_ack;
  logic tile_done;
  logic busy;

  integer seed;
  int errors;
  int done_count = 0;
  int ack_delay_max;
  int ack_wait;
  logic in_cycle;
  logic [31:0] cyc_adr;
  logic [out_word_width-1:0] cyc_dat;

  // expected writes from the reference model and observed writes from the slave
  logic [31:0] exp_adr [$];
  logic [out_word_width-1:0] exp_dat [$];
  logic [31:0] got_adr [$];
  logic [out_word_width-1:0] got_dat [$];
  logic [out_word_width-1:0] buf_mem [logic [31:0]];

  conv_out_top uut (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .mode     (mode),
    .cfg      (cfg),
    .out_base (out_base),
    .push     (push),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_ack   (wb_ack),
    .tile_done(tile_done),
    .busy     (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk)
  begin
    if (tile_done)
      done_count++;
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_word(input string name, input logic [out_word_width-1:0] got,
                            input logic [out_word_width-1:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("errors: %0d", errors + 1);
    $display("TEST FAILED");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // wishbone slave memory
  //////////////////////////////////////////////////
  initial
  begin
    wb_ack = 1'b0;
    in_cycle = 1'b0;
    ack_wait = 0;
    forever
    begin
      @(posedge clk);
      #2;
      if (wb_ack)
      begin
        // cycle closed at this edge
        check_flag("wb_cyc after ack", wb_cyc, 1'b0);
        check_flag("wb_stb after ack", wb_stb, 1'b0);
        wb_ack = 1'b0;
      end
      else if (wb_cyc && wb_stb)
      begin
        if (!in_cycle)
        begin
          in_cycle = 1'b1;
          cyc_adr = wb_adr;
          cyc_dat = wb_dat_w;
          ack_wait = (ack_delay_max == 0) ? 0 : $unsigned($random(seed)) % (ack_delay_max + 1);
        end
        if (ack_wait == 0)
        begin
          check_flag("wb_we", wb_we, 1'b1);
          check_flag("wb_sel all ones", &wb_sel, 1'b1);
          check_addr("wb_adr held", wb_adr, cyc_adr);
          check_word("wb_dat_w held", wb_dat_w, cyc_dat);
          got_adr.push_back(wb_adr);
          got_dat.push_back(wb_dat_w);
          buf_mem[wb_adr] = wb_dat_w;
          wb_ack = 1'b1;
          in_cycle = 1'b0;
        end
        else
        begin
          ack_wait--;
        end
      end
    end
  end

  function automatic tile_cfg_t make_cfg(input int ox, input int oy, input int of,
                                         input int poy, input int pof, input int of2pow);
    tile_cfg_t c;
    c = '0;
    c.ox_start = 16'(ox);
    c.oy_start = 16'(oy);
    c.of_start = 16'(of);
    c.pox = 16'd1;
    c.poy = 16'(poy);
    c.pof = 16'(pof);
    c.of_in_2pow = 4'(of2pow);
    return c;
  endfunction

  //////////////////////////////////////////////////
  // fill fifos and build the expected writes
  //////////////////////////////////////////////////
  task automatic push_word(input int k, input fifo_word_t w);
    @(posedge clk);
    #2;
    push.valid = 1'b1;
    push.index = 4'(k);
    push.data = w;
  endtask

  // walks the three loops and pushes a fresh entry wherever the walk pops
  task automatic prepare_tile(input logic md, input tile_cfg_t c, input logic [31:0] base);
    int oy;
    int of;
    int ch;
    int grp;
    int lg;
    int k;
    logic stop;
    fifo_word_t entry;
    logic [15:0] y;
    logic [15:0] f;
    exp_adr.delete();
    exp_dat.delete();
    entry = '0;
    grp = md ? 32 : 16;
    lg = md ? 5 : 4;
    for (oy = 1; oy <= c.poy; oy++)
    begin
      stop = 1'b0;
      for (of = 1; of <= c.pof && !stop; of += grp)
      begin
        for (ch = 1; ch <= grp && !stop; ch++)
        begin
          k = (oy - 1) * sa_row_num + ((of - 1) >> lg);
          if (!md || (ch % 2 == 1))
          begin
            entry = {$random(seed), $random(seed), $random(seed), $random(seed)};
            push_word(k, entry);
          end
          y = 16'(c.oy_start - 1 + oy);
          f = 16'(c.of_start - 1 + (of - 1) + ch);
          exp_adr.push_back(base + (32'(y) << c.of_in_2pow) + 32'(f));
          exp_dat.push_back((md && (ch % 2 == 0)) ? entry.hi : entry.lo);
          if (of - 1 + ch == c.pof)
            stop = 1'b1;
        end
      end
    end
    @(posedge clk);
    #2;
    push.valid = 1'b0;
  endtask

  task automatic run_tile(input logic md, input tile_cfg_t c, input logic [31:0] base,
                          input int exp_count);
    int d0;
    int n;
    int i;
    got_adr.delete();
    got_dat.delete();
    buf_mem.delete();
    prepare_tile(md, c, base);
    d0 = done_count;
    @(posedge clk);
    #2;
    mode = md;
    cfg = c;
    out_base = base;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    check_flag("busy after start", busy, 1'b1);
    n = 0;
    while (done_count == d0)
    begin
      @(negedge clk);
      n++;
      if (n > 5000)
        abort_on_timeout("tile_done");
    end
    repeat (5) @(negedge clk);
    check_flag("tile_done single pulse", done_count == d0 + 1, 1'b1);
    n = 0;
    while (busy)
    begin
      @(negedge clk);
      n++;
      if (n > 100)
        abort_on_timeout("busy to fall");
    end
    check_addr("model item count", exp_adr.size(), exp_count);
    check_addr("write count", got_adr.size(), exp_adr.size());
    for (i = 0; i < exp_adr.size() && i < got_adr.size(); i++)
    begin
      check_addr("wb_adr", got_adr[i], exp_adr[i]);
      check_word("wb_dat_w", got_dat[i], exp_dat[i]);
      check_word("buf_mem", buf_mem[exp_adr[i]], exp_dat[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic idle_after_reset();
    repeat (10)
    begin
      @(negedge clk);
      check_flag("wb_cyc", wb_cyc, 1'b0);
      check_flag("tile_done", tile_done, 1'b0);
      check_flag("busy", busy, 1'b0);
    end
  endtask

  task automatic single_group_mode0();
    ack_delay_max = 0;
    run_tile(1'b0, make_cfg(5, 1, 1, 1, 16, 6), 32'h0000_1000, 16);
  endtask

  task automatic partial_group_mode0();
    ack_delay_max = 0;
    run_tile(1'b0, make_cfg(2, 3, 9, 2, 40, 6), 32'h0000_2000, 80);
  endtask

  task automatic lo_hi_halves_mode1();
    ack_delay_max = 0;
    run_tile(1'b1, make_cfg(0, 1, 1, 1, 32, 5), 32'h0000_3000, 32);
  endtask

  task automatic random_ack_two_tiles();
    ack_delay_max = 3;
    run_tile(1'b1, make_cfg(7, 2, 1, 3, 40, 6), 32'h0000_4000, 120);
    // second tile from fresh fifo contents
    run_tile(1'b0, make_cfg(1, 4, 17, 2, 20, 7), 32'h0000_8000, 40);
  endtask

  initial
  begin
    seed = 32'hfa9f;
    errors = 0;
    ack_delay_max = 0;
    reset = 1'b1;
    start = 1'b0;
    mode = 1'b0;
    cfg = '0;
    out_base = '0;
    push = '0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    idle_after_reset();
    single_group_mode0();
    partial_group_mode0();
    lo_hi_halves_mode1();
    random_ack_two_tiles();
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* conv_out_top.f */
src/conv_out_pkg.sv
src/row_result_fifo.sv
src/conv_fifo_out_controller.sv
src/out_buf_writer.sv
src/conv_out_top.sv
verification/conv_out_tb.sv
